// ==== logic/draw_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module draw_sequencer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  move,
    input  wire                  init_busy,
    input  maze_pkg::tft_byte_t  init_data,
    input  wire                  init_dc,
    input  wire                  init_transmit,
    input  wire                  scene_busy,
    input  maze_pkg::tft_byte_t  scene_data,
    input  wire                  scene_dc,
    input  wire                  scene_transmit,
    input  wire                  player_busy,
    input  maze_pkg::tft_byte_t  player_data,
    input  wire                  player_dc,
    input  wire                  player_transmit,
    output logic                 init_enable,
    output logic                 scene_enable,
    output logic                 player_enable,
    output maze_pkg::tft_byte_t  spi_data,
    output logic                 spi_dc,
    output logic                 spi_transmit,
    output logic                 busy
);
    import maze_pkg::*;

    unit_t phase;
    unit_t next_phase;
    // power-up still to run
    logic boot;
    // unit has had one clock to raise busy
    logic armed;
    logic pending;
    logic cur_busy;

    assign init_enable = phase == unit_init;
    assign scene_enable = phase == unit_scene;
    assign player_enable = phase == unit_player;
    assign busy = phase != unit_none;

    always_comb begin
        case (phase)
            unit_init: begin
                next_phase = unit_scene;
                cur_busy = init_busy;
                spi_data = init_data;
                spi_dc = init_dc;
                spi_transmit = init_transmit;
            end
            unit_scene: begin
                next_phase = unit_player;
                cur_busy = scene_busy;
                spi_data = scene_data;
                spi_dc = scene_dc;
                spi_transmit = scene_transmit;
            end
            unit_player: begin
                next_phase = unit_none;
                cur_busy = player_busy;
                spi_data = player_data;
                spi_dc = player_dc;
                spi_transmit = player_transmit;
            end
            default: begin
                next_phase = unit_none;
                cur_busy = 1'b0;
                spi_data = '0;
                spi_dc = 1'b0;
                spi_transmit = 1'b0;
            end
        endcase
    end

    // ##############################
    // phase stepping
    always_ff @(posedge clk) begin
        if (!rst) begin
            phase <= unit_none;
            boot <= 1'b1;
            armed <= 1'b0;
            pending <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (move) begin
                pending <= 1'b1;
            end
            if (phase == unit_none) begin
                if (boot) begin
                    phase <= unit_init;
                    boot <= 1'b0;
                    armed <= 1'b0;
                end else if (move || pending) begin
                    phase <= unit_player;
                    pending <= 1'b0;
                    armed <= 1'b0;
                end
            end else if (armed && !cur_busy) begin
                phase <= next_phase;
                armed <= 1'b0;
                // scene is always followed by a player draw
                if (next_phase == unit_player) begin
                    pending <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/maze_pkg.sv ====
`default_nettype none

package maze_pkg;

    typedef logic [7:0] tft_byte_t;
    typedef logic [7:0] coord_t;
    typedef logic [15:0] rgb565_t;
    // position inside the window setup bytes
    typedef logic [3:0] win_idx_t;

    typedef enum logic [1:0] {
        unit_none,
        unit_init,
        unit_scene,
        unit_player
    } unit_t;

    // ##############################
    // panel commands
    localparam tft_byte_t cmd_swreset = 8'h01;
    localparam tft_byte_t cmd_slpout = 8'h11;
    localparam tft_byte_t cmd_colmod = 8'h3a;
    localparam tft_byte_t cmd_dispon = 8'h29;
    localparam tft_byte_t cmd_caset = 8'h2a;
    localparam tft_byte_t cmd_raset = 8'h2b;
    localparam tft_byte_t cmd_ramwr = 8'h2c;

    // power-up list, one entry per byte; 8'h55 selects 16 bpp
    localparam int init_len = 5;
    localparam tft_byte_t init_cmds [0:init_len-1] = '{
        cmd_swreset, cmd_slpout, cmd_colmod, 8'h55, cmd_dispon
    };
    // bit n belongs to entry n
    localparam logic [init_len-1:0] init_dc = 5'b01000;
    localparam logic [init_len-1:0] init_wait = 5'b00011;

    // caset, 4 data, raset, 4 data, ramwr
    localparam int win_len = 11;

    localparam rgb565_t wall_color = 16'h39e7;
    localparam rgb565_t path_color = 16'hffff;
    localparam rgb565_t player_color = 16'hf800;

    function automatic logic is_wall(coord_t col, coord_t row, coord_t w, coord_t h);
        int unsigned sum;
        sum = 3 * col + 5 * row;
        if (col == 8'd0 || row == 8'd0 || col == w - 8'd1 || row == h - 8'd1) begin
            return 1'b1;
        end
        return (sum % 7) == 0;
    endfunction

    // window setup byte, columns x0..x1 and rows y0..y1
    function automatic tft_byte_t win_byte(win_idx_t idx, coord_t x0, coord_t x1,
                                           coord_t y0, coord_t y1);
        case (idx)
            4'd0: return cmd_caset;
            4'd2: return x0;
            4'd4: return x1;
            4'd5: return cmd_raset;
            4'd7: return y0;
            4'd9: return y1;
            4'd10: return cmd_ramwr;
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic win_dc(win_idx_t idx);
        return !(idx == 4'd0 || idx == 4'd5 || idx == 4'd10);
    endfunction

endpackage

`default_nettype wire

// ==== logic/maze_tft.sv ====
`timescale 1ns/100ps
`default_nettype none

module maze_tft #(
    parameter int MAZE_W = 8,
    parameter int MAZE_H = 6,
    parameter int CELL_SIZE = 4,
    parameter int INIT_WAIT = 64
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               move,
    input  maze_pkg::coord_t  player_x,
    input  maze_pkg::coord_t  player_y,
    output logic              tft_clk,
    output logic              tft_mosi,
    output logic              tft_dc,
    output logic              busy
);
    import maze_pkg::*;

    tft_byte_t init_data, scene_data, player_data, spi_data;
    logic init_dc, scene_dc, player_dc, spi_dc;
    logic init_transmit, scene_transmit, player_transmit, spi_transmit;
    logic init_busy, scene_busy, player_busy, spi_busy;
    logic init_enable, scene_enable, player_enable;

    tft_spi spi_i (
        .clk(clk), .rst(rst),
        .data(spi_data), .dc(spi_dc), .transmit(spi_transmit),
        .tft_mosi(tft_mosi), .tft_dc(tft_dc), .tft_clk(tft_clk), .busy(spi_busy)
    );

    tft_init #(.INIT_WAIT(INIT_WAIT)) init_i (
        .clk(clk), .rst(rst), .enable(init_enable), .tft_busy(spi_busy),
        .tft_data(init_data), .tft_dc(init_dc), .tft_transmit(init_transmit),
        .busy(init_busy)
    );

    scene_exhibitor #(
        .MAZE_W(MAZE_W), .MAZE_H(MAZE_H), .CELL_SIZE(CELL_SIZE)
    ) scene_i (
        .clk(clk), .rst(rst), .enable(scene_enable), .tft_busy(spi_busy),
        .tft_data(scene_data), .tft_dc(scene_dc), .tft_transmit(scene_transmit),
        .busy(scene_busy)
    );

    player #(.CELL_SIZE(CELL_SIZE)) player_i (
        .clk(clk), .rst(rst), .enable(player_enable), .tft_busy(spi_busy),
        .x(player_x), .y(player_y),
        .tft_data(player_data), .tft_dc(player_dc), .tft_transmit(player_transmit),
        .busy(player_busy)
    );

    draw_sequencer sequencer_i (
        .clk(clk), .rst(rst), .move(move),
        .init_busy(init_busy), .init_data(init_data),
        .init_dc(init_dc), .init_transmit(init_transmit),
        .scene_busy(scene_busy), .scene_data(scene_data),
        .scene_dc(scene_dc), .scene_transmit(scene_transmit),
        .player_busy(player_busy), .player_data(player_data),
        .player_dc(player_dc), .player_transmit(player_transmit),
        .init_enable(init_enable), .scene_enable(scene_enable),
        .player_enable(player_enable),
        .spi_data(spi_data), .spi_dc(spi_dc), .spi_transmit(spi_transmit),
        .busy(busy)
    );

endmodule

`default_nettype wire

// ==== logic/player.sv ====
`timescale 1ns/100ps
`default_nettype none

module player #(
    parameter int CELL_SIZE = 4
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  enable,
    input  wire                  tft_busy,
    input  maze_pkg::coord_t     x,
    input  maze_pkg::coord_t     y,
    output maze_pkg::tft_byte_t  tft_data,
    output logic                 tft_dc,
    output logic                 tft_transmit,
    output logic                 busy
);
    import maze_pkg::*;

    localparam int pix_w = $clog2(CELL_SIZE * CELL_SIZE + 1);
    localparam logic [pix_w-1:0] pix_last = pix_w'(CELL_SIZE * CELL_SIZE - 1);
    localparam coord_t cell_last = coord_t'(CELL_SIZE - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_wait_spi,
        st_done
    } state_t;

    state_t state;
    logic in_hdr;
    win_idx_t hdr_idx;
    logic lo_byte;
    logic [pix_w-1:0] pix_cnt;
    coord_t x_q, y_q;

    assign tft_data = in_hdr ?
                      win_byte(hdr_idx, x_q, x_q + cell_last, y_q, y_q + cell_last) :
                      lo_byte ? player_color[7:0] : player_color[15:8];
    assign tft_dc = in_hdr ? win_dc(hdr_idx) : 1'b1;
    assign tft_transmit = (state == st_send) && !tft_busy;

    // position is sampled once per draw
    always_ff @(posedge clk) begin
        if (state == st_idle && enable) begin
            x_q <= x;
            y_q <= y;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            busy <= 1'b0;
            in_hdr <= 1'b1;
            hdr_idx <= '0;
            lo_byte <= 1'b0;
            pix_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (enable) begin
                        state <= st_send;
                        busy <= 1'b1;
                        in_hdr <= 1'b1;
                        hdr_idx <= '0;
                        lo_byte <= 1'b0;
                        pix_cnt <= '0;
                    end
                end
                st_send: begin
                    if (!tft_busy) begin
                        state <= st_wait_spi;
                    end
                end
                st_wait_spi: begin
                    if (!tft_busy) begin
                        state <= st_send;
                        if (in_hdr) begin
                            if (hdr_idx == 4'(win_len - 1)) begin
                                in_hdr <= 1'b0;
                            end else begin
                                hdr_idx <= hdr_idx + 1'b1;
                            end
                        end else if (!lo_byte) begin
                            lo_byte <= 1'b1;
                        end else if (pix_cnt == pix_last) begin
                            state <= st_done;
                            busy <= 1'b0;
                        end else begin
                            lo_byte <= 1'b0;
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (!enable) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/scene_exhibitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module scene_exhibitor #(
    parameter int MAZE_W = 8,
    parameter int MAZE_H = 6,
    parameter int CELL_SIZE = 4
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  enable,
    input  wire                  tft_busy,
    output maze_pkg::tft_byte_t  tft_data,
    output logic                 tft_dc,
    output logic                 tft_transmit,
    output logic                 busy
);
    import maze_pkg::*;

    localparam coord_t cell_last = coord_t'(CELL_SIZE - 1);
    localparam coord_t w_last = coord_t'(MAZE_W - 1);
    localparam coord_t h_last = coord_t'(MAZE_H - 1);
    localparam coord_t col_last = coord_t'(MAZE_W * CELL_SIZE - 1);
    localparam coord_t row_last = coord_t'(MAZE_H * CELL_SIZE - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_wait_spi,
        st_done
    } state_t;

    state_t state;
    logic in_hdr;
    win_idx_t hdr_idx;
    logic lo_byte;
    // pixel inside the cell, and the cell itself
    coord_t px, py;
    coord_t cell_x, cell_y;
    rgb565_t color;
    logic last_pix;

    assign color = is_wall(cell_x, cell_y, coord_t'(MAZE_W), coord_t'(MAZE_H)) ?
                   wall_color : path_color;
    assign last_pix = px == cell_last && cell_x == w_last &&
                      py == cell_last && cell_y == h_last;

    assign tft_data = in_hdr ? win_byte(hdr_idx, 8'd0, col_last, 8'd0, row_last) :
                      lo_byte ? color[7:0] : color[15:8];
    assign tft_dc = in_hdr ? win_dc(hdr_idx) : 1'b1;
    assign tft_transmit = (state == st_send) && !tft_busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            busy <= 1'b0;
            in_hdr <= 1'b1;
            hdr_idx <= '0;
            lo_byte <= 1'b0;
            px <= '0;
            py <= '0;
            cell_x <= '0;
            cell_y <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (enable) begin
                        state <= st_send;
                        busy <= 1'b1;
                        in_hdr <= 1'b1;
                        hdr_idx <= '0;
                        lo_byte <= 1'b0;
                        px <= '0;
                        py <= '0;
                        cell_x <= '0;
                        cell_y <= '0;
                    end
                end
                st_send: begin
                    if (!tft_busy) begin
                        state <= st_wait_spi;
                    end
                end
                st_wait_spi: begin
                    if (!tft_busy) begin
                        state <= st_send;
                        if (in_hdr) begin
                            if (hdr_idx == 4'(win_len - 1)) begin
                                in_hdr <= 1'b0;
                            end else begin
                                hdr_idx <= hdr_idx + 1'b1;
                            end
                        end else if (!lo_byte) begin
                            lo_byte <= 1'b1;
                        end else begin
                            lo_byte <= 1'b0;
                            // left to right, then next pixel row
                            if (px != cell_last) begin
                                px <= px + 1'b1;
                            end else begin
                                px <= '0;
                                if (cell_x != w_last) begin
                                    cell_x <= cell_x + 1'b1;
                                end else begin
                                    cell_x <= '0;
                                    if (py != cell_last) begin
                                        py <= py + 1'b1;
                                    end else begin
                                        py <= '0;
                                        cell_y <= cell_y + 1'b1;
                                    end
                                end
                            end
                            if (last_pix) begin
                                state <= st_done;
                                busy <= 1'b0;
                            end
                        end
                    end
                end
                default: begin
                    if (!enable) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/tft_init.sv ====
`timescale 1ns/100ps
`default_nettype none

module tft_init #(
    parameter int INIT_WAIT = 64
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  enable,
    input  wire                  tft_busy,
    output maze_pkg::tft_byte_t  tft_data,
    output logic                 tft_dc,
    output logic                 tft_transmit,
    output logic                 busy
);
    import maze_pkg::*;

    localparam int idx_w = $clog2(init_len);
    localparam int cnt_w = $clog2(INIT_WAIT + 1);
    localparam logic [idx_w-1:0] idx_last = idx_w'(init_len - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_send,
        st_wait_spi,
        st_delay,
        st_done
    } state_t;

    state_t state;
    logic [idx_w-1:0] idx;
    logic [cnt_w-1:0] wait_cnt;

    assign tft_data = init_cmds[idx];
    assign tft_dc = init_dc[idx];
    assign tft_transmit = (state == st_send) && !tft_busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            busy <= 1'b0;
            idx <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (enable) begin
                        state <= st_send;
                        busy <= 1'b1;
                        idx <= '0;
                    end
                end
                st_send: begin
                    if (!tft_busy) begin
                        state <= st_wait_spi;
                    end
                end
                st_wait_spi: begin
                    if (!tft_busy) begin
                        if (init_wait[idx]) begin
                            state <= st_delay;
                            wait_cnt <= cnt_w'(INIT_WAIT - 1);
                        end else if (idx == idx_last) begin
                            state <= st_done;
                            busy <= 1'b0;
                        end else begin
                            state <= st_send;
                            idx <= idx + 1'b1;
                        end
                    end
                end
                st_delay: begin
                    // panel needs time after reset and sleep out
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else if (idx == idx_last) begin
                        state <= st_done;
                        busy <= 1'b0;
                    end else begin
                        state <= st_send;
                        idx <= idx + 1'b1;
                    end
                end
                default: begin
                    if (!enable) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/tft_spi.sv ====
`timescale 1ns/100ps
`default_nettype none

module tft_spi (
    input  wire                  clk,
    input  wire                  rst,
    input  maze_pkg::tft_byte_t  data,
    input  wire                  dc,
    input  wire                  transmit,
    output logic                 tft_mosi,
    output logic                 tft_dc,
    output logic                 tft_clk,
    output logic                 busy
);
    import maze_pkg::*;

    tft_byte_t shift;
    logic [2:0] bit_cnt;
    // low half, then high half of each bit
    logic phase;

    assign tft_clk = phase;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            phase <= 1'b0;
            tft_mosi <= 1'b0;
            tft_dc <= 1'b0;
            bit_cnt <= 3'd0;
        end else if (!busy) begin
            if (transmit) begin
                busy <= 1'b1;
                tft_mosi <= data[7];
                shift <= {data[6:0], 1'b0};
                tft_dc <= dc;
                bit_cnt <= 3'd0;
            end
        end else if (!phase) begin
            // panel samples mosi here
            phase <= 1'b1;
        end else begin
            phase <= 1'b0;
            if (bit_cnt == 3'd7) begin
                busy <= 1'b0;
                tft_mosi <= 1'b0;
                tft_dc <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 3'd1;
                tft_mosi <= shift[7];
                shift <= {shift[6:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== maze_tft.f ====
logic/maze_pkg.sv
logic/tft_spi.sv
logic/tft_init.sv
logic/scene_exhibitor.sv
logic/player.sv
logic/draw_sequencer.sv
logic/maze_tft.sv
tests/tft_spi_monitor.sv
tests/maze_tft_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the maze_tft testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f maze_tft.f --top-module maze_tft_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vmaze_tft_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== tests/maze_tft_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module maze_tft_tb;
    import maze_pkg::*;

    localparam int maze_w = 8;
    localparam int maze_h = 6;
    localparam int cell_size = 4;
    localparam int init_wait_clks = 64;
    localparam int scr_w = maze_w * cell_size;
    localparam int scr_h = maze_h * cell_size;

    localparam int kind_init = 0;
    localparam int kind_scene = 1;
    localparam int kind_player = 2;

    localparam int idle_moves = 4;
    // auto draw, one move during it, idle moves, one move during a draw
    localparam int draw_count = idle_moves + 3;
    localparam int init_bytes = 5;
    localparam int scene_bytes = 11 + scr_w * scr_h * 2;
    localparam int player_bytes = 11 + cell_size * cell_size * 2;
    localparam int total_bytes = init_bytes + scene_bytes + draw_count * player_bytes;
    localparam int watchdog_cycles = total_bytes * 17 + 2 * init_wait_clks
                                     + total_bytes * 4 + 4000;

    logic clk;
    logic rst;
    logic move;
    coord_t player_x;
    coord_t player_y;
    logic tft_clk;
    logic tft_mosi;
    logic tft_dc;
    logic busy;

    logic [7:0] rx_byte;
    logic rx_dc;
    int rx_count;
    int edge_count;
    int dc_changes;

    logic [8:0] exp_q[$];
    logic [8:0] got_q[$];
    logic [31:0] lcg_state = 32'hf76e_2131;
    int pos_x = 0;
    int pos_y = 0;
    int errors = 0;
    int checked = 0;
    int expected_total = 0;
    int rx_seen = 0;
    int cycle = 0;
    int edges_seen = 0;
    int last_edge_cycle = 0;

    maze_tft #(
        .MAZE_W(maze_w), .MAZE_H(maze_h), .CELL_SIZE(cell_size), .INIT_WAIT(init_wait_clks)
    ) maze_tft_i (
        .clk(clk), .rst(rst), .move(move), .player_x(player_x), .player_y(player_y),
        .tft_clk(tft_clk), .tft_mosi(tft_mosi), .tft_dc(tft_dc), .busy(busy)
    );

    tft_spi_monitor spi_monitor_i (
        .tft_clk(tft_clk), .tft_mosi(tft_mosi), .tft_dc(tft_dc),
        .rx_byte(rx_byte), .rx_dc(rx_dc), .rx_count(rx_count),
        .edge_count(edge_count), .dc_changes(dc_changes)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ##############################
    // reference model
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic wall_cell(input int cx, input int cy);
        if (cx == 0 || cy == 0 || cx == maze_w - 1 || cy == maze_h - 1) begin
            return 1'b1;
        end
        return ((3 * cx + 5 * cy) % 7) == 0;
    endfunction

    function automatic int phase_len(input int kind);
        if (kind == kind_init) begin
            return init_bytes;
        end else if (kind == kind_scene) begin
            return scene_bytes;
        end
        return player_bytes;
    endfunction

    // {dc, byte} for byte idx of a phase
    function automatic logic [8:0] ref_byte(input int kind, input int x, input int y,
                                            input int idx);
        int x0, x1, y0, y1, pix;
        logic [15:0] color;
        if (kind == kind_init) begin
            case (idx)
                0: return {1'b0, 8'h01};
                1: return {1'b0, 8'h11};
                2: return {1'b0, 8'h3a};
                3: return {1'b1, 8'h55};
                default: return {1'b0, 8'h29};
            endcase
        end
        if (kind == kind_scene) begin
            x0 = 0;
            x1 = scr_w - 1;
            y0 = 0;
            y1 = scr_h - 1;
        end else begin
            x0 = x;
            x1 = x + cell_size - 1;
            y0 = y;
            y1 = y + cell_size - 1;
        end
        case (idx)
            0: return {1'b0, 8'h2a};
            2: return {1'b1, 8'(x0)};
            4: return {1'b1, 8'(x1)};
            5: return {1'b0, 8'h2b};
            7: return {1'b1, 8'(y0)};
            9: return {1'b1, 8'(y1)};
            10: return {1'b0, 8'h2c};
            default: ;
        endcase
        if (idx < 11) begin
            return {1'b1, 8'h00};
        end
        pix = (idx - 11) / 2;
        if (kind == kind_player) begin
            color = player_color;
        end else if (wall_cell((pix % scr_w) / cell_size, (pix / scr_w) / cell_size)) begin
            color = wall_color;
        end else begin
            color = path_color;
        end
        // high byte first
        return ((idx - 11) % 2 == 0) ? {1'b1, color[15:8]} : {1'b1, color[7:0]};
    endfunction

    task automatic expect_phase(input int kind, input int x, input int y);
        int n;
        int i;
        n = phase_len(kind);
        for (i = 0; i < n; i++) begin
            exp_q.push_back(ref_byte(kind, x, y, i));
        end
        expected_total += n;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // cell aligned, inside the screen
    task automatic pick_position();
        lcg_state = lcg_next(lcg_state);
        pos_x = ((lcg_state >> 16) % maze_w) * cell_size;
        lcg_state = lcg_next(lcg_state);
        pos_y = ((lcg_state >> 16) % maze_h) * cell_size;
    endtask

    task automatic move_to_new_position();
        pick_position();
        @(posedge clk);
        #2;
        player_x = coord_t'(pos_x);
        player_y = coord_t'(pos_y);
        move = 1'b1;
        expect_phase(kind_player, pos_x, pos_y);
        @(posedge clk);
        #2 move = 1'b0;
    endtask

    task automatic wait_bytes(input int n);
        while (checked < n) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (checked < expected_total || busy);
    endtask

    // ##############################
    // compare process
    always @(negedge clk) begin : compare
        logic [8:0] got_word;
        logic [8:0] exp_word;
        if (rx_count != rx_seen) begin
            got_q.push_back({rx_dc, rx_byte});
            rx_seen = rx_count;
        end
        while (got_q.size() > 0) begin
            got_word = got_q.pop_front();
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected extra byte %h with dc %b", got_word[7:0], got_word[8]);
            end else begin
                exp_word = exp_q.pop_front();
                check_value("tft_data", got_word[7:0], exp_word[7:0]);
                check_value("tft_dc", got_word[8], exp_word[8]);
            end
            checked++;
        end
    end

    // idle pins and init wait gaps
    always @(negedge clk) begin
        if (cycle > 0 && (!rst || !busy)) begin
            check_value("tft_clk", tft_clk, 1'b0);
            check_value("tft_mosi", tft_mosi, 1'b0);
            check_value("tft_dc", tft_dc, 1'b0);
        end
        if (edge_count != edges_seen) begin
            // first edges of bytes 1 and 2 follow the two waits
            if ((edge_count == 9 || edge_count == 17) &&
                cycle - last_edge_cycle < init_wait_clks) begin
                errors++;
                $display("init wait too short, only %0d clocks before byte %0d",
                         cycle - last_edge_cycle, edge_count / 8);
            end
            edges_seen = edge_count;
            last_edge_cycle = cycle;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("output stalled, test not done after %0d clocks", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        int i;
        rst = 1'b0;
        move = 1'b0;
        pick_position();
        player_x = coord_t'(pos_x);
        player_y = coord_t'(pos_y);
        expect_phase(kind_init, 0, 0);
        expect_phase(kind_scene, 0, 0);
        expect_phase(kind_player, pos_x, pos_y);
        repeat (16) @(posedge clk);
        #2 rst = 1'b1;

        // move while the first player draw runs
        wait_bytes(init_bytes + scene_bytes + 1);
        move_to_new_position();
        wait_idle();

        for (i = 0; i < idle_moves; i++) begin
            move_to_new_position();
            if (i == 1) begin
                wait_bytes(expected_total - player_bytes + 1);
                move_to_new_position();
            end
            wait_idle();
        end

        // nothing more should show up
        repeat (200) @(posedge clk);
        check_value("rx_count", rx_seen, expected_total);
        check_value("tft_clk_edges", edge_count, 8 * expected_total);
        check_value("dc_changes", dc_changes, 0);
        check_value("busy", busy, 0);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected bytes never arrived", exp_q.size());
        end

        $display("errors: %0d, bytes checked: %0d of %0d", errors, checked, expected_total);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tft_spi_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module tft_spi_monitor (
    input  wire         tft_clk,
    input  wire         tft_mosi,
    input  wire         tft_dc,
    output logic [7:0]  rx_byte,
    output logic        rx_dc,
    output int          rx_count,
    output int          edge_count,
    output int          dc_changes
);

    logic [7:0] shift = 8'h00;
    logic [7:0] byte_q = 8'h00;
    logic dc_q = 1'b0;
    // dc seen on the first bit of the byte
    logic first_dc = 1'b0;
    int bit_cnt = 0;
    int count_q = 0;
    int edges_q = 0;
    int changes_q = 0;

    assign rx_byte = byte_q;
    assign rx_dc = dc_q;
    assign rx_count = count_q;
    assign edge_count = edges_q;
    assign dc_changes = changes_q;

    // ##############################
    // panel side, mosi valid on the rising edge
    always @(posedge tft_clk) begin
        edges_q = edges_q + 1;
        shift = {shift[6:0], tft_mosi};
        if (bit_cnt == 0) begin
            first_dc = tft_dc;
        end else if (tft_dc !== first_dc) begin
            changes_q = changes_q + 1;
        end
        if (bit_cnt == 7) begin
            byte_q = shift;
            dc_q = first_dc;
            count_q = count_q + 1;
            bit_cnt = 0;
        end else begin
            bit_cnt = bit_cnt + 1;
        end
    end

endmodule

`default_nettype wire
